// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_TEXT="SOME TESTS FAILED"
PASS_TEXT="ALL TESTS PASSED"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f sources.f --top-module tb_mem_subsystem -Mdir "$BUILD_DIR" -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation ended abnormally with status $sim_status"
    exit 1
fi
if ! grep -q "$PASS_TEXT" "$LOG_FILE"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+src
src/mem_pkg.sv
src/mem_stage.sv
src/mem_bank.sv
src/mem_subsystem.sv
testbench/mem_subsystem_assert.sv
testbench/tb_mem_subsystem.sv

// ==== src/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

// Single-port word memory with byte-masked writes.
// Reads land in one response register that can be held by the consumer.
module mem_bank
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      req_ready,

    output logic      resp_valid,
    output mem_resp_t resp,
    input  logic      resp_ready
);

    localparam int DEPTH = 2 ** $bits(addr_t);
    localparam int LANES = $bits(mask_t);

    data_t     mem_q [DEPTH];
    logic      accept;
    logic      rd_accept;
    logic      wr_accept;
    logic      resp_valid_q;
    mem_resp_t resp_q;

    // Replace the masked bytes of a word.
    function automatic data_t merge_bytes(
        input data_t old_word,
        input data_t new_word,
        input mask_t mask
    );
        data_t result;
        result = old_word;
        for (int b = 0; b < LANES; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // A held response blocks reads and writes alike.
    assign req_ready = ~resp_valid_q | resp_ready;

    assign accept    = req_valid & req_ready;
    assign rd_accept = accept & req.read_enable;
    assign wr_accept = accept & (|req.write_enable);

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem_q[req.addr] <= merge_bytes(mem_q[req.addr], req.data, req.write_enable);
        end
    end

    // Old word is sampled, so write plus read returns prior data.
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            resp_q.id   <= req.id;
            resp_q.data <= mem_q[req.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else if (rd_accept) begin
            resp_valid_q <= 1'b1;           // Refill, possibly same cycle as drain.
        end else if (resp_ready) begin
            resp_valid_q <= 1'b0;
        end
    end

    assign resp_valid = resp_valid_q;
    assign resp       = resp_q;

endmodule

`default_nettype wire

// ==== src/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Word address width; the bank holds 2**MEM_ADDR_WIDTH words.
`define MEM_ADDR_WIDTH 8

// Data word width, a multiple of 8.
`define MEM_DATA_WIDTH 32

// Request tag width.
`define MEM_ID_WIDTH 4

// Register slots in the request stage.
`define MEM_REQ_LATENCY 2

// Register slots in the response stage.
`define MEM_RESP_LATENCY 1

`endif

// ==== src/mem_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    localparam int MEM_MASK_WIDTH = `MEM_DATA_WIDTH / 8;  // One enable per byte.

    typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`MEM_DATA_WIDTH-1:0] data_t;
    typedef logic [MEM_MASK_WIDTH-1:0]  mask_t;
    typedef logic [`MEM_ID_WIDTH-1:0]   id_t;

    // Request toward the bank.
    typedef struct packed {
        logic  read_enable;
        mask_t write_enable;  // Nonzero means write.
        addr_t addr;
        data_t data;
        id_t   id;
    } mem_req_t;

    // Read response, tagged with the request id.
    typedef struct packed {
        id_t   id;
        data_t data;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Valid/ready pipeline of LATENCY register slots for any packed payload.
// Each slot moves on when the next one is empty or itself moving on,
// so bubbles get squeezed out under back-pressure.
module mem_stage #(
    parameter type T       = logic,
    parameter int  LATENCY = 1
) (
    input  logic clk,
    input  logic rst_n,

    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    generate
        if (LATENCY == 0) begin : g_bypass

            assign out_valid = in_valid;     // Plain wires, no storage.
            assign out_data  = in_data;
            assign in_ready  = out_ready;

        end else begin : g_slots

            logic [LATENCY-1:0] full_q;
            logic [LATENCY-1:0] advance;
            logic [LATENCY-1:0] load;
            T                   slot_q [LATENCY];

            // Readiness ripples back from the output slot.
            always_comb begin
                advance[LATENCY-1] = full_q[LATENCY-1] & out_ready;
                for (int i = LATENCY - 2; i >= 0; i--) begin
                    advance[i] = full_q[i] & (~full_q[i+1] | advance[i+1]);
                end
            end

            assign in_ready = ~full_q[0] | advance[0];

            always_comb begin
                load[0] = in_valid & in_ready;
                for (int i = 1; i < LATENCY; i++) begin
                    load[i] = advance[i-1];  // Fed by predecessor.
                end
            end

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    full_q <= '0;
                end else begin
                    for (int i = 0; i < LATENCY; i++) begin
                        full_q[i] <= load[i] | (full_q[i] & ~advance[i]);
                    end
                end
            end

            // Payload slots.
            always_ff @(posedge clk) begin
                if (load[0]) begin
                    slot_q[0] <= in_data;
                end
                for (int i = 1; i < LATENCY; i++) begin
                    if (load[i]) begin
                        slot_q[i] <= slot_q[i-1];
                    end
                end
            end

            assign out_valid = full_q[LATENCY-1];
            assign out_data  = slot_q[LATENCY-1];

        end
    endgenerate

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

// Request pipeline, memory bank and response pipeline in a row.
module mem_subsystem
    import mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      req_ready,

    output logic      resp_valid,
    output mem_resp_t resp,
    input  logic      resp_ready
);

    logic      bank_req_valid;
    logic      bank_req_ready;
    mem_req_t  bank_req;

    logic      bank_resp_valid;
    logic      bank_resp_ready;
    mem_resp_t bank_resp;

    mem_stage #(
        .T       (mem_req_t),
        .LATENCY (`MEM_REQ_LATENCY)
    ) req_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_data   (req),
        .in_ready  (req_ready),
        .out_valid (bank_req_valid),
        .out_data  (bank_req),
        .out_ready (bank_req_ready)
    );

    mem_bank bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (bank_req_valid),
        .req        (bank_req),
        .req_ready  (bank_req_ready),
        .resp_valid (bank_resp_valid),
        .resp       (bank_resp),
        .resp_ready (bank_resp_ready)
    );

    mem_stage #(
        .T       (mem_resp_t),
        .LATENCY (`MEM_RESP_LATENCY)
    ) resp_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (bank_resp_valid),
        .in_data   (bank_resp),
        .in_ready  (bank_resp_ready),
        .out_valid (resp_valid),
        .out_data  (resp),
        .out_ready (resp_ready)
    );

endmodule

`default_nettype wire

// ==== testbench/mem_subsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

// Handshake rules on the two external ports of the subsystem.
module mem_subsystem_assert
    import mem_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      req_valid,
    input mem_req_t  req,
    input logic      req_ready,
    input logic      resp_valid,
    input mem_resp_t resp,
    input logic      resp_ready,
    input logic      bank_req_valid,
    input logic      bank_resp_valid
);

    req_valid_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid
    ) else $error("req_valid dropped before the request was accepted");

    req_payload_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> $stable(req)
    ) else $error("request payload changed while waiting for acceptance");

    resp_valid_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid
    ) else $error("resp_valid dropped before the response was taken");

    resp_payload_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> $stable(resp)
    ) else $error("response payload changed while held");

    // Pipelines come out of reset empty.
    reset_empty: assert property (
        @(posedge clk)
        $rose(rst_n) |-> !resp_valid && !bank_req_valid && !bank_resp_valid
    ) else $error("a valid flag was high in the first cycle after reset");

endmodule

bind mem_subsystem mem_subsystem_assert checks (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid       (req_valid),
    .req             (req),
    .req_ready       (req_ready),
    .resp_valid      (resp_valid),
    .resp            (resp),
    .resp_ready      (resp_ready),
    .bank_req_valid  (bank_req_valid),
    .bank_resp_valid (bank_resp_valid)
);

`default_nettype wire

// ==== testbench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_mem_subsystem
    import mem_pkg::*;
();

    localparam int RESET_CYCLES   = 10;
    localparam int RESP_LATENCY   = `MEM_REQ_LATENCY + 1 + `MEM_RESP_LATENCY;
    localparam int DEPTH          = 2 ** `MEM_ADDR_WIDTH;
    localparam int NUM_PAIRS      = 8;     // Write and read pairs per test.
    localparam int NUM_BURST      = 32;
    localparam int NUM_BP         = 10;
    localparam int BP_HOLD        = 20;    // Cycles with responses held.
    localparam int NUM_RANDOM     = 300;
    localparam int TOTAL_REQUESTS = DEPTH + 4 * NUM_PAIRS + NUM_BURST + NUM_BP + NUM_RANDOM;
    localparam int STALL_CYCLES   = RESET_CYCLES + BP_HOLD + NUM_RANDOM;
    localparam int CYCLE_LIMIT    = 2 * (TOTAL_REQUESTS * RESP_LATENCY + STALL_CYCLES);

    logic      clk = 1'b0;
    logic      rst_n;
    logic      req_valid;
    mem_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    mem_resp_t resp;
    logic      resp_ready = 1'b1;         // Owned by the stall generator.

    logic [31:0] stim_state    = 32'hb615_69f6;
    logic [31:0] stall_state   = ~32'hb615_69f6;
    logic        random_stalls = 1'b0;
    logic        resp_level    = 1'b1;
    logic        check_latency = 1'b0;
    logic        just_reset    = 1'b0;
    string       test_name     = "reset";
    id_t         next_id       = '0;
    int          cycle         = 0;
    int          timeout_count = 0;

    data_t     shadow [DEPTH];            // Reference copy of the bank.
    mem_resp_t expect_q [$];
    int        issue_cycle_q [$];

    mem_subsystem uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    function automatic data_t fill_word(input addr_t a);
        return {a, ~a, a ^ 8'h5a, a + 8'h31};
    endfunction

    function automatic data_t apply_byte_mask(input data_t old_word, input data_t new_word,
                                              input mask_t mask);
        data_t bits;
        for (int k = 0; k < $bits(data_t); k++) begin
            bits[k] = mask[k / 8];
        end
        return (old_word & ~bits) | (new_word & bits);
    endfunction

    function automatic mem_req_t make_read(input addr_t a);
        mem_req_t r;
        r             = '0;
        r.read_enable = 1'b1;
        r.addr        = a;
        r.id          = next_id;
        next_id       = next_id + 1'b1;
        return r;
    endfunction

    function automatic mem_req_t make_write(input addr_t a, input data_t d, input mask_t m);
        mem_req_t r;
        r              = '0;
        r.write_enable = m;
        r.addr         = a;
        r.data         = d;
        return r;
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string field, input string expected,
                                   input string actual);
        fail_now($sformatf("mismatch in %s (%s): expected %s, actual %s",
                           test_name, field, expected, actual));
    endtask

    task automatic record_request(input mem_req_t r);
        mem_resp_t e;
        if (|r.write_enable) begin
            shadow[r.addr] = apply_byte_mask(shadow[r.addr], r.data, r.write_enable);
        end
        if (r.read_enable) begin
            e.id   = r.id;
            e.data = shadow[r.addr];
            expect_q.push_back(e);
            issue_cycle_q.push_back(cycle);
        end
    endtask

    task automatic check_response(input mem_resp_t got);
        mem_resp_t want;
        int        issued;
        assert (expect_q.size() != 0)
            else fail_now("a response arrived with no read outstanding");
        if (expect_q.size() != 0) begin
            want   = expect_q.pop_front();
            issued = issue_cycle_q.pop_front();
            assert (got.id === want.id)
                else report_mismatch("id", $sformatf("%h", want.id), $sformatf("%h", got.id));
            assert (got.data === want.data)
                else report_mismatch("data", $sformatf("%h", want.data),
                                     $sformatf("%h", got.data));
            assert (!check_latency || cycle - issued == RESP_LATENCY)
                else report_mismatch("latency", $sformatf("%0d", RESP_LATENCY),
                                     $sformatf("%0d", cycle - issued));
        end
    endtask

    // Samples settled values at the rising edge.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n || just_reset) begin
            assert (!resp_valid) else fail_now("resp_valid was high during or after reset");
            assert (req_ready) else fail_now("req_ready was low during or after reset");
        end
        just_reset = !rst_n;
        if (rst_n) begin
            if (req_valid && req_ready) begin
                record_request(req);
            end
            if (resp_valid && resp_ready) begin
                check_response(resp);
            end
        end
    end

    always @(negedge clk) begin
        if (random_stalls) begin
            stall_state = lcg_step(stall_state);
            resp_ready  = (stall_state[31:30] != 2'b00);  // Stalls about one cycle in four.
        end else begin
            resp_ready = resp_level;
        end
    end

    always @(posedge clk) begin
        timeout_count = timeout_count + 1;
        if (timeout_count >= CYCLE_LIMIT) begin
            fail_now($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic drive_request(input mem_req_t r);
        @(negedge clk);
        req_valid = 1'b1;
        req       = r;
    endtask

    task automatic wait_accept();
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
    endtask

    task automatic send_request(input mem_req_t r);
        drive_request(r);
        wait_accept();
    endtask

    task automatic go_idle();
        @(negedge clk);
        req_valid = 1'b0;
        req       = '0;
    endtask

    task automatic wait_drained();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic fill_memory();
        test_name = "fill";
        for (int a = 0; a < DEPTH; a++) begin
            send_request(make_write(addr_t'(a), fill_word(addr_t'(a)), '1));
        end
        go_idle();
    endtask

    task automatic full_word_pairs();
        logic [31:0] a;
        data_t       d;
        test_name     = "full_word";
        check_latency = 1'b1;
        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = next_stim();
            d = next_stim();
            send_request(make_write(a[31:24], d, '1));
            send_request(make_read(a[31:24]));
        end
        go_idle();
        wait_drained();
    endtask

    task automatic masked_write_pairs();
        logic [31:0] a;
        data_t       d;
        test_name = "byte_mask";
        for (int i = 0; i < NUM_PAIRS; i++) begin
            a = next_stim();
            d = next_stim();
            send_request(make_write(a[31:24], d, mask_t'(i + 1)));  // Masks 1 to 8.
            send_request(make_read(a[31:24]));
        end
        go_idle();
        wait_drained();
    endtask

    task automatic read_burst();
        logic [31:0] a;
        test_name = "order_latency";
        for (int i = 0; i < NUM_BURST; i++) begin
            a = next_stim();
            drive_request(make_read(a[31:24]));
            @(posedge clk);
            assert (req_ready) else fail_now("a burst read was not accepted in its own cycle");
        end
        go_idle();
        wait_drained();
    endtask

    task automatic back_pressure_hold();
        mem_resp_t   held;
        logic [31:0] a;
        int          accepted;
        test_name     = "back_pressure";
        check_latency = 1'b0;
        accepted      = 0;
        @(posedge clk);
        resp_level = 1'b0;
        a = next_stim();
        drive_request(make_read(a[31:24]));
        @(posedge clk);
        while (req_ready && accepted < NUM_BP) begin
            accepted++;
            a = next_stim();
            drive_request(make_read(a[31:24]));
            @(posedge clk);
        end
        assert (!req_ready) else fail_now("req_ready stayed high with responses held");
        held = resp;
        repeat (BP_HOLD) begin
            @(posedge clk);
            assert (!req_ready) else fail_now("req_ready rose while responses were held");
            assert (resp_valid && resp === held)
                else report_mismatch("held response", $sformatf("%h", held),
                                     $sformatf("%h", resp));
        end
        resp_level = 1'b1;
        wait_accept();
        for (int i = accepted + 1; i < NUM_BP; i++) begin
            a = next_stim();
            send_request(make_read(a[31:24]));
        end
        go_idle();
        wait_drained();
    endtask

    task automatic random_traffic();
        logic [31:0] kind;
        logic [31:0] a;
        data_t       d;
        test_name = "random_mix";
        @(posedge clk);
        random_stalls = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            kind = next_stim();
            a    = next_stim();
            d    = next_stim();
            if (kind[31]) begin
                send_request(make_write(a[31:24], d,
                                        (kind[27:24] != 4'h0) ? kind[27:24] : 4'hf));
            end else begin
                send_request(make_read(a[31:24]));
            end
        end
        go_idle();
        @(posedge clk);
        random_stalls = 1'b0;
        wait_drained();
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        fill_memory();
        full_word_pairs();
        masked_write_pairs();
        read_burst();
        back_pressure_hold();
        random_traffic();
        repeat (4) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
